// File: logic/ctrl_pkg.sv
// core controller package
// shared widths, selector and cause encodings, and the bundles
// passed between the controller blocks
`default_nettype none

package ctrl_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int unsigned XLEN      = 32;
  localparam int unsigned FAST_IRQS = 15;
  localparam int unsigned FAST_ID_W = 4;
  localparam int unsigned CAUSE_W   = 6;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // fetch address source
  typedef enum logic [1:0] {
    PC_BOOT = 2'd0,
    PC_JUMP = 2'd1,
    PC_EXC  = 2'd2,
    PC_ERET = 2'd3
  } pc_sel_e;

  // trap vector offset
  typedef enum logic {
    EXC_PC_EXC = 1'b0,
    EXC_PC_IRQ = 1'b1
  } exc_pc_sel_e;

  // top bit marks an interrupt, fast irq n is {2'b11, n}
  typedef enum logic [CAUSE_W-1:0] {
    EXC_CAUSE_INSN_ADDR_MISA     = 6'd0,
    EXC_CAUSE_INSTR_ACCESS_FAULT = 6'd1,
    EXC_CAUSE_ILLEGAL_INSN       = 6'd2,
    EXC_CAUSE_BREAKPOINT         = 6'd3,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'd5,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'd7,
    EXC_CAUSE_ECALL_UMODE        = 6'd8,
    EXC_CAUSE_ECALL_MMODE        = 6'd11,
    EXC_CAUSE_IRQ_SOFTWARE_M     = {1'b1, 5'd3},
    EXC_CAUSE_IRQ_TIMER_M        = {1'b1, 5'd7},
    EXC_CAUSE_IRQ_EXTERNAL_M     = {1'b1, 5'd11},
    EXC_CAUSE_IRQ_NM             = {1'b1, 5'd31}
  } exc_cause_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////

  // raw decoder flags, not yet qualified with valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebrk;
    logic csr_flush;
  } dec_flags_t;

  // contents of the IF-ID register
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] instr;
    logic [15:0]     instr_c;
    logic            is_compressed;
    logic            fetch_err;
    logic            fetch_err_plus2;
    logic [XLEN-1:0] pc;
  } id_instr_t;

  // interrupt lines already masked by mie
  typedef struct packed {
    logic                 software;
    logic                 timer;
    logic                 external;
    logic [FAST_IRQS-1:0] fast;
  } irqs_t;

  typedef struct packed {
    exc_cause_e      cause;
    logic [XLEN-1:0] mtval;
  } exc_info_t;

  // special requests, all qualified with valid
  typedef struct packed {
    logic mret;
    logic wfi;
    logic flush_only;
    logic pc_change;
  } sys_req_t;

  // CSR file update strobes and trap data
  typedef struct packed {
    logic            save_if;
    logic            save_id;
    logic            restore_mret;
    logic            save_cause;
    exc_cause_e      cause;
    logic [XLEN-1:0] mtval;
  } csr_ctrl_t;

endpackage

`default_nettype wire

// File: logic/exc_detect.sv
// exception detection for the ID stage
// qualifies decoder flags, flops the requests and picks the winning
// exception with its cause and trap value
`timescale 1ns/1ps
`default_nettype none

module exc_detect import ctrl_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  dec_flags_t      dec_i,
  input  id_instr_t       instr_i,
  input  priv_lvl_e       priv_mode_i,
  input  logic            mstatus_tw_i,
  input  logic            load_err_i,
  input  logic            store_err_i,
  input  logic [XLEN-1:0] lsu_addr_i,
  input  logic            in_flush_i,
  output logic            id_exception_o,
  output logic            exc_pending_o,
  output sys_req_t        sys_req_o,
  output exc_info_t       exc_info_o
);

  logic ecall, mret, wfi, ebrk, csr_flush, fetch_err;
  logic illegal_umode;
  logic illegal_d, illegal_q;
  logic exc_req_d, exc_req_q;
  logic load_err_q, store_err_q;
  logic fetch_err_prio, illegal_prio, ecall_prio, ebrk_prio, store_prio, load_prio;

  // decoder does not look at valid
  assign ecall     = dec_i.ecall     & instr_i.valid;
  assign mret      = dec_i.mret      & instr_i.valid;
  assign wfi       = dec_i.wfi       & instr_i.valid;
  assign ebrk      = dec_i.ebrk      & instr_i.valid;
  assign csr_flush = dec_i.csr_flush & instr_i.valid;
  assign fetch_err = instr_i.fetch_err & instr_i.valid;

  // mret and trapped wfi need M-mode
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) & (mret | (mstatus_tw_i & wfi));

  // requests drop while the FSM flushes so a handled one is not seen twice
  assign illegal_d = ((dec_i.illegal & instr_i.valid) | illegal_umode) & ~in_flush_i;
  assign exc_req_d = (ecall | ebrk | illegal_d | fetch_err) & ~in_flush_i;

  assign id_exception_o = exc_req_d;

  assign sys_req_o.mret       = mret;
  assign sys_req_o.wfi        = wfi;
  assign sys_req_o.flush_only = wfi | csr_flush;
  // LSU errors arrive without valid from ID
  assign sys_req_o.pc_change  = mret | exc_req_d | load_err_i | store_err_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_req_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_req_q   <= exc_req_d;
      load_err_q  <= load_err_i & ~in_flush_i;
      store_err_q <= store_err_i & ~in_flush_i;
    end
  end

  assign exc_pending_o = exc_req_q | load_err_q | store_err_q;

  // fixed priority, fetch error first, load fault last
  always_comb begin
    fetch_err_prio = 1'b0;
    illegal_prio   = 1'b0;
    ecall_prio     = 1'b0;
    ebrk_prio      = 1'b0;
    store_prio     = 1'b0;
    load_prio      = 1'b0;
    if (fetch_err) begin
      fetch_err_prio = 1'b1;
    end else if (illegal_q) begin
      illegal_prio = 1'b1;
    end else if (ecall) begin
      ecall_prio = 1'b1;
    end else if (ebrk) begin
      ebrk_prio = 1'b1;
    end else if (store_err_q) begin
      store_prio = 1'b1;
    end else if (load_err_q) begin
      load_prio = 1'b1;
    end
  end

  // cause and trap value of the winner
  always_comb begin
    exc_info_o.cause = EXC_CAUSE_INSN_ADDR_MISA;
    exc_info_o.mtval = '0;
    if (fetch_err_prio) begin
      exc_info_o.cause = EXC_CAUSE_INSTR_ACCESS_FAULT;
      // error in the upper half of an unaligned fetch
      exc_info_o.mtval = instr_i.fetch_err_plus2 ? instr_i.pc + XLEN'(2) : instr_i.pc;
    end else if (illegal_prio) begin
      exc_info_o.cause = EXC_CAUSE_ILLEGAL_INSN;
      exc_info_o.mtval = instr_i.is_compressed ? {{(XLEN-16){1'b0}}, instr_i.instr_c} :
                                                 instr_i.instr;
    end else if (ecall_prio) begin
      exc_info_o.cause = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE :
                                                       EXC_CAUSE_ECALL_UMODE;
    end else if (ebrk_prio) begin
      exc_info_o.cause = EXC_CAUSE_BREAKPOINT;
    end else if (store_prio) begin
      exc_info_o.cause = EXC_CAUSE_STORE_ACCESS_FAULT;
      exc_info_o.mtval = lsu_addr_i;
    end else if (load_prio) begin
      exc_info_o.cause = EXC_CAUSE_LOAD_ACCESS_FAULT;
      exc_info_o.mtval = lsu_addr_i;
    end
  end

  // a flopped request must still have exactly one winner a cycle later
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    exc_pending_o |-> $onehot({fetch_err_prio, illegal_prio, ecall_prio,
                               ebrk_prio, store_prio, load_prio}));

endmodule

`default_nettype wire

// File: logic/irq_arbiter.sv
// interrupt arbitration
// decides whether an interrupt is taken and encodes its cause
`timescale 1ns/1ps
`default_nettype none

module irq_arbiter import ctrl_pkg::*; (
  input  irqs_t      irqs_i,
  input  logic       irq_nm_i,
  input  logic       irq_pending_i,
  input  logic       mstatus_mie_i,
  input  logic       nmi_mode_i,
  output logic       irq_take_o,
  output exc_cause_e irq_cause_o,
  output logic       irq_nmi_o
);

  logic [FAST_ID_W-1:0] fast_id;

  // nested NMIs are not supported and nothing interrupts an NMI handler
  assign irq_take_o = ~nmi_mode_i & (irq_nm_i | (irq_pending_i & mstatus_mie_i));
  assign irq_nmi_o  = irq_nm_i & ~nmi_mode_i;

  // lowest index wins, so scan downwards
  always_comb begin
    fast_id = '0;
    for (int i = FAST_IRQS - 1; i >= 0; i--) begin
      if (irqs_i.fast[i]) begin
        fast_id = FAST_ID_W'(i);
      end
    end
  end

  ////////////////////////////////////////
  // cause encoding
  ////////////////////////////////////////

  // NMI, fast, external, software, timer
  always_comb begin
    irq_cause_o = EXC_CAUSE_INSN_ADDR_MISA;
    if (irq_nm_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_NM;
    end else if (irqs_i.fast != '0) begin
      // bit 5 flags an interrupt, bit 4 adds 16 to the index
      irq_cause_o = exc_cause_e'({2'b11, fast_id});
    end else if (irqs_i.external) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irqs_i.software) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else if (irqs_i.timer) begin
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

endmodule

`default_nettype wire

// File: logic/ctrl_fsm.sv
// controller state machine
// boot, decode, flush and trap entry, interrupt entry and WFI sleep
// drives fetch redirection, CSR strobes and ID-stage stall and flush
`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm import ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        instr_valid_i,
  input  logic        stall_id_i,
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  input  sys_req_t    sys_req_i,
  input  logic        exc_pending_i,
  input  exc_info_t   exc_info_i,
  input  logic        irq_take_i,
  input  exc_cause_e  irq_cause_i,
  input  logic        irq_nmi_i,
  input  logic        irq_pending_i,
  input  logic        irq_nm_i,
  output logic        in_flush_o,
  output logic        nmi_mode_o,
  output logic        ctrl_busy_o,
  output logic        controller_run_o,
  output logic        instr_req_o,
  output logic        pc_set_o,
  output pc_sel_e     pc_mux_o,
  output exc_pc_sel_e exc_pc_mux_o,
  output csr_ctrl_t   csr_o,
  output logic        id_in_ready_o,
  output logic        instr_valid_clear_o,
  output logic        flush_id_o
);

  typedef enum logic [2:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_fsm_e;

  ctrl_fsm_e ctrl_fsm_cs, ctrl_fsm_ns;
  logic      nmi_mode_d, nmi_mode_q;
  logic      special_req;
  logic      halt_if, retain_id, flush_id;

  assign special_req = sys_req_i.pc_change | sys_req_i.flush_only;

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////

  always_comb begin
    ctrl_fsm_ns      = ctrl_fsm_cs;
    nmi_mode_d       = nmi_mode_q;
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    controller_run_o = 1'b0;
    // mux values only matter while pc_set_o is high
    pc_set_o         = 1'b0;
    pc_mux_o         = PC_BOOT;
    exc_pc_mux_o     = EXC_PC_IRQ;
    csr_o            = '0;
    csr_o.cause      = EXC_CAUSE_INSN_ADDR_MISA;
    halt_if          = 1'b0;
    retain_id        = 1'b0;
    flush_id         = 1'b0;

    unique case (ctrl_fsm_cs)
      RESET: begin
        instr_req_o = 1'b0;
        // no boot redirect while reset is still held
        pc_set_o    = rst_ni;
        ctrl_fsm_ns = BOOT_SET;
      end
      BOOT_SET: begin
        // boot address into the fetch PC
        pc_set_o    = 1'b1;
        ctrl_fsm_ns = FIRST_FETCH;
      end
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        ctrl_fsm_ns = SLEEP;
      end
      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // wake on any pending line, even if globally disabled
        if (irq_nm_i || irq_pending_i) begin
          ctrl_fsm_ns = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end
      FIRST_FETCH: begin
        if (id_in_ready_o) begin
          ctrl_fsm_ns = DECODE;
        end
        // keep the current instruction, stop IF before redirect
        if (irq_take_i) begin
          ctrl_fsm_ns = IRQ_TAKEN;
          halt_if     = 1'b1;
        end
      end
      DECODE: begin
        controller_run_o = 1'b1;
        pc_mux_o         = PC_JUMP;
        // hold the instruction in ID so FLUSH can act on it
        if (special_req) begin
          retain_id   = 1'b1;
          ctrl_fsm_ns = FLUSH;
        end
        if (branch_set_i || jump_set_i) begin
          pc_set_o = 1'b1;
        end
        // irq waits for ID to drain
        if (irq_take_i) begin
          halt_if = 1'b1;
          if (!stall_id_i && !special_req && !instr_valid_i) begin
            ctrl_fsm_ns = IRQ_TAKEN;
          end
        end
      end
      FLUSH: begin
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        ctrl_fsm_ns = DECODE;
        if (exc_pending_i) begin
          // trap entry, mepc from the PC in ID
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          exc_pc_mux_o     = EXC_PC_EXC;
          csr_o.save_id    = 1'b1;
          csr_o.save_cause = 1'b1;
          csr_o.cause      = exc_info_i.cause;
          csr_o.mtval      = exc_info_i.mtval;
        end else if (sys_req_i.mret) begin
          pc_set_o           = 1'b1;
          pc_mux_o           = PC_ERET;
          csr_o.restore_mret = 1'b1;
          // handler return leaves NMI mode
          nmi_mode_d         = 1'b0;
        end else if (sys_req_i.wfi) begin
          ctrl_fsm_ns = WAIT_SLEEP;
        end
      end
      IRQ_TAKEN: begin
        pc_mux_o     = PC_EXC;
        exc_pc_mux_o = EXC_PC_IRQ;
        // line may have dropped since DECODE
        if (irq_take_i) begin
          pc_set_o         = 1'b1;
          csr_o.save_if    = 1'b1;
          csr_o.save_cause = 1'b1;
          csr_o.cause      = irq_cause_i;
          if (irq_nmi_i) begin
            nmi_mode_d = 1'b1;
          end
        end
        ctrl_fsm_ns = DECODE;
      end
      default: begin
        instr_req_o = 1'b0;
        ctrl_fsm_ns = RESET;
      end
    endcase
  end

  ////////////////////////////////////////
  // ID-stage handshake
  ////////////////////////////////////////

  assign id_in_ready_o = ~stall_id_i & ~halt_if & ~retain_id;
  // retained or stalled instructions keep valid unless flushed
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;
  assign flush_id_o  = flush_id;
  assign in_flush_o  = (ctrl_fsm_cs == FLUSH);
  assign nmi_mode_o  = nmi_mode_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_fsm_cs <= RESET;
      nmi_mode_q  <= 1'b0;
    end else begin
      ctrl_fsm_cs <= ctrl_fsm_ns;
      nmi_mode_q  <= nmi_mode_d;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl_fsm_cs inside {RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH,
                        IRQ_TAKEN});

  // a redirect out of FLUSH is a trap or a return requested in DECODE
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pc_set_o && ctrl_fsm_cs == FLUSH) |->
      pc_mux_o inside {PC_EXC, PC_ERET} && $past(sys_req_i.pc_change));

endmodule

`default_nettype wire

// File: logic/core_controller.sv
// main control unit of the two-stage core
// ties exception detection, interrupt arbitration and the FSM together
`timescale 1ns/1ps
`default_nettype none

module core_controller import ctrl_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  // decoder and IF-ID register
  input  dec_flags_t      dec_i,
  input  id_instr_t       instr_i,
  // LSU
  input  logic            load_err_i,
  input  logic            store_err_i,
  input  logic [XLEN-1:0] lsu_addr_i,
  // branch unit and ID stall
  input  logic            branch_set_i,
  input  logic            jump_set_i,
  input  logic            stall_id_i,
  // interrupts and privilege state
  input  irqs_t           irqs_i,
  input  logic            irq_nm_i,
  input  logic            irq_pending_i,
  input  logic            mstatus_mie_i,
  input  logic            mstatus_tw_i,
  input  priv_lvl_e       priv_mode_i,
  // fetch
  output logic            instr_req_o,
  output logic            pc_set_o,
  output pc_sel_e         pc_mux_o,
  output exc_pc_sel_e     exc_pc_mux_o,
  // ID stage
  output logic            id_in_ready_o,
  output logic            instr_valid_clear_o,
  output logic            flush_id_o,
  output logic            id_exception_o,
  // status and CSR file
  output logic            ctrl_busy_o,
  output logic            controller_run_o,
  output logic            nmi_mode_o,
  output csr_ctrl_t       csr_o
);

  logic       in_flush, exc_pending;
  sys_req_t   sys_req;
  exc_info_t  exc_info;
  logic       irq_take, irq_nmi;
  exc_cause_e irq_cause;

  exc_detect i_exc_detect (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .dec_i          (dec_i),
    .instr_i        (instr_i),
    .priv_mode_i    (priv_mode_i),
    .mstatus_tw_i   (mstatus_tw_i),
    .load_err_i     (load_err_i),
    .store_err_i    (store_err_i),
    .lsu_addr_i     (lsu_addr_i),
    .in_flush_i     (in_flush),
    .id_exception_o (id_exception_o),
    .exc_pending_o  (exc_pending),
    .sys_req_o      (sys_req),
    .exc_info_o     (exc_info)
  );

  irq_arbiter i_irq_arbiter (
    .irqs_i        (irqs_i),
    .irq_nm_i      (irq_nm_i),
    .irq_pending_i (irq_pending_i),
    .mstatus_mie_i (mstatus_mie_i),
    .nmi_mode_i    (nmi_mode_o),
    .irq_take_o    (irq_take),
    .irq_cause_o   (irq_cause),
    .irq_nmi_o     (irq_nmi)
  );

  ctrl_fsm i_ctrl_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_i.valid),
    .stall_id_i          (stall_id_i),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .sys_req_i           (sys_req),
    .exc_pending_i       (exc_pending),
    .exc_info_i          (exc_info),
    .irq_take_i          (irq_take),
    .irq_cause_i         (irq_cause),
    .irq_nmi_i           (irq_nmi),
    .irq_pending_i       (irq_pending_i),
    .irq_nm_i            (irq_nm_i),
    .in_flush_o          (in_flush),
    .nmi_mode_o          (nmi_mode_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .controller_run_o    (controller_run_o),
    .instr_req_o         (instr_req_o),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .exc_pc_mux_o        (exc_pc_mux_o),
    .csr_o               (csr_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o)
  );

endmodule

`default_nettype wire

// File: verification/tb_core_controller.sv
// directed testbench for the core controller
// boot, exceptions and their priority, LSU faults, interrupts with NMI,
// MRET return and WFI sleep with wake-up
`timescale 1ns/1ps
`default_nettype none

module tb_core_controller import ctrl_pkg::*; ();

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_TESTS   = 6;
  localparam int WATCHDOG_NS = NUM_TESTS * 200 * CLK_PERIOD;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  dec_flags_t  dec;
  id_instr_t   instr;
  logic        load_err;
  logic        store_err;
  logic [31:0] lsu_addr;
  logic        branch_set;
  logic        jump_set;
  logic        stall_id;
  irqs_t       irqs;
  logic        irq_nm;
  logic        irq_pending;
  logic        mstatus_mie;
  logic        mstatus_tw;
  priv_lvl_e   priv_mode;
  logic        instr_req;
  logic        pc_set;
  pc_sel_e     pc_mux;
  exc_pc_sel_e exc_pc_mux;
  logic        id_in_ready;
  logic        instr_valid_clear;
  logic        flush_id;
  logic        id_exception;
  logic        ctrl_busy;
  logic        controller_run;
  logic        nmi_mode;
  csr_ctrl_t   csr;

  int unsigned errors;
  int unsigned checks;
  logic [31:0] rnd;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  core_controller i_dut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .dec_i               (dec),
    .instr_i             (instr),
    .load_err_i          (load_err),
    .store_err_i         (store_err),
    .lsu_addr_i          (lsu_addr),
    .branch_set_i        (branch_set),
    .jump_set_i          (jump_set),
    .stall_id_i          (stall_id),
    .irqs_i              (irqs),
    .irq_nm_i            (irq_nm),
    .irq_pending_i       (irq_pending),
    .mstatus_mie_i       (mstatus_mie),
    .mstatus_tw_i        (mstatus_tw),
    .priv_mode_i         (priv_mode),
    .instr_req_o         (instr_req),
    .pc_set_o            (pc_set),
    .pc_mux_o            (pc_mux),
    .exc_pc_mux_o        (exc_pc_mux),
    .id_in_ready_o       (id_in_ready),
    .instr_valid_clear_o (instr_valid_clear),
    .flush_id_o          (flush_id),
    .id_exception_o      (id_exception),
    .ctrl_busy_o         (ctrl_busy),
    .controller_run_o    (controller_run),
    .nmi_mode_o          (nmi_mode),
    .csr_o               (csr)
  );

  // hard stop in case a wait loop or the DUT gets stuck
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $finish;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // fast line n maps to cause {2'b11, n}, first set line from index 0 up
  function automatic logic [5:0] fast_irq_cause(input logic [14:0] lines);
    for (int i = 0; i < 15; i++) begin
      if (lines[i]) begin
        return {2'b11, 4'(i)};
      end
    end
    return 6'd0;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  // outputs settle well before the next rising edge
  task automatic settle();
    #(CLK_PERIOD / 4);
  endtask

  task automatic drive_idle();
    dec         = '0;
    instr       = '0;
    load_err    = 1'b0;
    store_err   = 1'b0;
    lsu_addr    = '0;
    branch_set  = 1'b0;
    jump_set    = 1'b0;
    stall_id    = 1'b0;
    irqs        = '0;
    irq_nm      = 1'b0;
    irq_pending = 1'b0;
  endtask

  task automatic set_priv(input priv_lvl_e p);
    @(negedge clk_i);
    priv_mode = p;
  endtask

  // one cycle in DECODE, returns settled in the FLUSH cycle
  task automatic present_instr(input dec_flags_t d, input id_instr_t ins,
                               input logic exp_id_exc);
    @(negedge clk_i);
    dec   = d;
    instr = ins;
    settle();
    check_val("id_exception_o", id_exception, exp_id_exc);
    // special requests hold the instruction in ID
    check_val("id_in_ready_o", id_in_ready, 1'b0);
    check_val("instr_valid_clear_o", instr_valid_clear, 1'b0);
    @(negedge clk_i);
    settle();
    // FLUSH drops the held instruction
    check_val("flush_id_o", flush_id, 1'b1);
    check_val("instr_valid_clear_o", instr_valid_clear, 1'b1);
  endtask

  // IF-ID register empties after FLUSH
  task automatic release_id();
    @(negedge clk_i);
    drive_idle();
    settle();
  endtask

  task automatic check_trap(input logic [5:0] exp_cause, input logic [31:0] exp_mtval);
    check_val("pc_set_o", pc_set, 1'b1);
    check_val("pc_mux_o", pc_mux, PC_EXC);
    check_val("exc_pc_mux_o", exc_pc_mux, EXC_PC_EXC);
    check_val("csr_o.save_id", csr.save_id, 1'b1);
    check_val("csr_o.save_cause", csr.save_cause, 1'b1);
    check_val("csr_o.cause", csr.cause, exp_cause);
    check_val("csr_o.mtval", csr.mtval, exp_mtval);
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_boot();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_val("pc_set_o in reset", pc_set, 1'b0);
    check_val("csr_o strobes in reset", {csr.save_if, csr.save_id, csr.restore_mret,
                                        csr.save_cause}, 4'h0);
    check_val("nmi_mode_o in reset", nmi_mode, 1'b0);
    check_val("id_exception_o in reset", id_exception, 1'b0);
    rst_ni = 1'b1;
    // RESET then BOOT_SET, both redirect to the boot address
    for (int cyc = 0; cyc < 2; cyc++) begin
      settle();
      check_val("pc_set_o", pc_set, 1'b1);
      check_val("pc_mux_o", pc_mux, PC_BOOT);
      check_val("instr_req_o", instr_req, cyc == 1);
      check_val("csr_o strobes", {csr.save_if, csr.save_id, csr.restore_mret,
                                  csr.save_cause}, 4'h0);
      @(negedge clk_i);
    end
    // FIRST_FETCH
    settle();
    check_val("pc_set_o", pc_set, 1'b0);
    check_val("id_in_ready_o", id_in_ready, 1'b1);
    @(negedge clk_i);
    settle();
    check_val("controller_run_o", controller_run, 1'b1);
    // branch and jump redirect in the same DECODE cycle
    @(negedge clk_i);
    branch_set = 1'b1;
    settle();
    check_val("pc_set_o", pc_set, 1'b1);
    check_val("pc_mux_o", pc_mux, PC_JUMP);
    @(negedge clk_i);
    branch_set = 1'b0;
    jump_set   = 1'b1;
    settle();
    check_val("pc_set_o", pc_set, 1'b1);
    check_val("pc_mux_o", pc_mux, PC_JUMP);
    @(negedge clk_i);
    jump_set = 1'b0;
    settle();
    check_val("pc_set_o", pc_set, 1'b0);
  endtask

  task automatic test_illegal();
    dec_flags_t d;
    id_instr_t  ins;
    d         = '0;
    d.illegal = 1'b1;
    rnd       = xorshift32(rnd);
    ins       = '0;
    ins.valid = 1'b1;
    ins.instr = rnd;
    rnd       = xorshift32(rnd);
    ins.pc    = {rnd[31:1], 1'b0};
    present_instr(d, ins, 1'b1);
    check_trap(EXC_CAUSE_ILLEGAL_INSN, ins.instr);
    release_id();
    // compressed form reports the 16-bit encoding
    rnd               = xorshift32(rnd);
    ins.is_compressed = 1'b1;
    ins.instr_c       = rnd[15:0];
    present_instr(d, ins, 1'b1);
    check_trap(EXC_CAUSE_ILLEGAL_INSN, {16'h0000, ins.instr_c});
    release_id();
    // MRET from U-mode is a privilege violation
    set_priv(PRIV_LVL_U);
    rnd               = xorshift32(rnd);
    d                 = '0;
    d.mret            = 1'b1;
    ins.is_compressed = 1'b0;
    ins.instr         = rnd;
    present_instr(d, ins, 1'b1);
    check_trap(EXC_CAUSE_ILLEGAL_INSN, ins.instr);
    release_id();
    set_priv(PRIV_LVL_M);
  endtask

  task automatic test_priority();
    dec_flags_t  d;
    id_instr_t   ins;
    logic [31:0] exp_mtval;
    for (int k = 0; k < 2; k++) begin
      d                   = '0;
      d.illegal           = 1'b1;
      d.ecall             = 1'b1;
      rnd                 = xorshift32(rnd);
      ins                 = '0;
      ins.valid           = 1'b1;
      ins.fetch_err       = 1'b1;
      ins.fetch_err_plus2 = k[0];
      ins.pc              = {rnd[31:1], 1'b0};
      rnd                 = xorshift32(rnd);
      ins.instr           = rnd;
      // upper half of an unaligned fetch faulted
      exp_mtval = ins.fetch_err_plus2 ? ins.pc + 32'd2 : ins.pc;
      present_instr(d, ins, 1'b1);
      check_trap(EXC_CAUSE_INSTR_ACCESS_FAULT, exp_mtval);
      release_id();
    end
    d       = '0;
    d.ecall = 1'b1;
    ins     = '0;
    ins.valid = 1'b1;
    ins.instr = rnd;
    present_instr(d, ins, 1'b1);
    check_trap(EXC_CAUSE_ECALL_MMODE, 32'h0);
    release_id();
    set_priv(PRIV_LVL_U);
    present_instr(d, ins, 1'b1);
    check_trap(EXC_CAUSE_ECALL_UMODE, 32'h0);
    release_id();
    set_priv(PRIV_LVL_M);
  endtask

  task automatic lsu_fault(input logic ld, input logic st, input logic [5:0] exp_cause);
    logic [31:0] addr;
    rnd  = xorshift32(rnd);
    addr = rnd;
    @(negedge clk_i);
    load_err  = ld;
    store_err = st;
    lsu_addr  = addr;
    // strobes last one cycle, the address stays
    @(negedge clk_i);
    load_err  = 1'b0;
    store_err = 1'b0;
    settle();
    check_trap(exp_cause, addr);
    release_id();
  endtask

  task automatic test_lsu_faults();
    lsu_fault(1'b1, 1'b0, EXC_CAUSE_LOAD_ACCESS_FAULT);
    lsu_fault(1'b0, 1'b1, EXC_CAUSE_STORE_ACCESS_FAULT);
    lsu_fault(1'b1, 1'b1, EXC_CAUSE_STORE_ACCESS_FAULT);
  endtask

  // lines held through IRQ_TAKEN, dropped once back in DECODE
  task automatic take_irq(input irqs_t lines, input logic nm, input logic [5:0] exp_cause);
    @(negedge clk_i);
    irqs        = lines;
    irq_nm      = nm;
    irq_pending = 1'b1;
    mstatus_mie = 1'b1;
    @(negedge clk_i);
    settle();
    check_val("pc_set_o", pc_set, 1'b1);
    check_val("pc_mux_o", pc_mux, PC_EXC);
    check_val("exc_pc_mux_o", exc_pc_mux, EXC_PC_IRQ);
    check_val("csr_o.save_if", csr.save_if, 1'b1);
    check_val("csr_o.save_cause", csr.save_cause, 1'b1);
    check_val("csr_o.cause", csr.cause, exp_cause);
    @(negedge clk_i);
    drive_idle();
    mstatus_mie = 1'b0;
    settle();
  endtask

  task automatic test_irq_nmi();
    irqs_t      lines;
    dec_flags_t d;
    id_instr_t  ins;
    rnd            = xorshift32(rnd);
    lines.software = 1'b1;
    lines.timer    = 1'b1;
    lines.external = 1'b1;
    lines.fast     = rnd[14:0] | 15'h0404;
    take_irq(lines, 1'b0, fast_irq_cause(lines.fast));
    check_val("nmi_mode_o", nmi_mode, 1'b0);
    take_irq(lines, 1'b1, EXC_CAUSE_IRQ_NM);
    check_val("nmi_mode_o", nmi_mode, 1'b1);
    // handler return
    d         = '0;
    d.mret    = 1'b1;
    ins       = '0;
    ins.valid = 1'b1;
    ins.instr = rnd;
    present_instr(d, ins, 1'b0);
    check_val("pc_set_o", pc_set, 1'b1);
    check_val("pc_mux_o", pc_mux, PC_ERET);
    check_val("csr_o.restore_mret", csr.restore_mret, 1'b1);
    check_val("csr_o.save_cause", csr.save_cause, 1'b0);
    release_id();
    check_val("nmi_mode_o", nmi_mode, 1'b0);
  endtask

  task automatic test_wfi_sleep();
    dec_flags_t d;
    id_instr_t  ins;
    int         n;
    d         = '0;
    d.wfi     = 1'b1;
    ins       = '0;
    ins.valid = 1'b1;
    present_instr(d, ins, 1'b0);
    release_id();
    n = 0;
    while (ctrl_busy && n < 3) begin
      @(negedge clk_i);
      settle();
      n++;
    end
    assert (!ctrl_busy) else begin
      errors++;
      $display("ctrl_busy_o did not fall within three cycles of the WFI");
    end
    repeat (4) begin
      @(negedge clk_i);
      settle();
      check_val("ctrl_busy_o", ctrl_busy, 1'b0);
      check_val("instr_req_o", instr_req, 1'b0);
    end
    // wake-up needs no global enable
    @(negedge clk_i);
    irq_pending = 1'b1;
    settle();
    check_val("ctrl_busy_o", ctrl_busy, 1'b1);
    n = 0;
    while (!instr_req && n < 5) begin
      @(negedge clk_i);
      settle();
      n++;
    end
    assert (instr_req) else begin
      errors++;
      $display("instr_req_o did not return after wake-up from sleep");
    end
    @(negedge clk_i);
    irq_pending = 1'b0;
    settle();
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    rst_ni      = 1'b0;
    errors      = 0;
    checks      = 0;
    rnd         = 32'hcc0a_41c7;
    mstatus_mie = 1'b0;
    mstatus_tw  = 1'b0;
    priv_mode   = PRIV_LVL_M;
    drive_idle();
    test_boot();
    test_illegal();
    test_priority();
    test_lsu_faults();
    test_irq_nmi();
    test_wfi_sleep();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
logic/ctrl_pkg.sv
logic/exc_detect.sv
logic/irq_arbiter.sv
logic/ctrl_fsm.sv
logic/core_controller.sv
verification/tb_core_controller.sv

// File: Bender.yml
package:
  name: core_controller

sources:
  - logic/ctrl_pkg.sv
  - logic/exc_detect.sv
  - logic/irq_arbiter.sv
  - logic/ctrl_fsm.sv
  - logic/core_controller.sv
  - target: test
    files:
      - verification/tb_core_controller.sv
